// ==== tb.f ====
+incdir+rtl
rtl/fp_slice_pkg.sv
rtl/fp_noncomp_lane.sv
rtl/slice_result_packer.sv
rtl/noncomp_multifmt_slice.sv
tb/slice_checker.sv
tb/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the slice testbench with Verilator
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module tb_top -f tb.f -o sim_tb \
  && ./obj_dir/sim_tb | awk '{ print } /^PASS: all tests$/ { ok = 1 } END { exit !ok }' \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== tb/tb_top.sv ====
// Directed testbench for the non-computational SIMD slice
// Inputs change on the rising edge, outputs are sampled on the falling edge
// The run stops at a fixed cycle limit

`timescale 1ns/1ns
`include "slice_settings.svh"

module tb_top;

  localparam int MaxCycles = 2000;

  logic                              clk_i = 1'b0;
  logic                              rst_n_i, flush_i;
  logic [`SLICE_WIDTH-1:0]           operand_a_i, operand_b_i;
  fp_slice_pkg::operation_e          op_i;
  logic                              op_mod_i;
  fp_slice_pkg::fp_format_e          fmt_i;
  logic                              vectorial_op_i;
  logic [`SLICE_TAG_BITS-1:0]        tag_i;
  logic [`SLICE_NUM_LANES-1:0]       simd_mask_i;
  logic                              in_valid_i, in_ready_o;
  logic [`SLICE_WIDTH-1:0]           result_o;
  logic                              invalid_o;
  logic [`SLICE_TAG_BITS-1:0]        tag_o;
  logic                              out_valid_o, out_ready_i, busy_o;

  int seed = 3;
  int cyc = 0;
  int value_errors = 0;
  int other_errors = 0;
  logic [31:0] exp_res[$];
  logic        exp_inv[$];
  logic [3:0]  exp_tag[$];
  int          rx_cyc[$];

  noncomp_multifmt_slice dut_i (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= MaxCycles) begin
      $display("Timeout: run stopped after %0d cycles", cyc);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic logic value_less(input logic sx, input logic [30:0] mx,
                                      input logic sy, input logic [30:0] my);
    if (sx != sy) return sx;  // Negative below positive, -0 below +0
    return sx ? (mx > my) : (mx < my);
  endfunction

  function automatic logic [31:0] lane_model(input logic [31:0] a, input logic [31:0] b,
      input fp_slice_pkg::operation_e op, input logic max_sel, input logic half,
      output logic inv);
    logic        sa, sb, na, nb, qa, qb, s;
    logic [30:0] ma, mb;
    if (half) begin
      sa = a[15];
      sb = b[15];
      ma = {16'b0, a[14:0]};
      mb = {16'b0, b[14:0]};
      na = (a[14:10] == 5'h1F) && (a[9:0] != 0);
      nb = (b[14:10] == 5'h1F) && (b[9:0] != 0);
      qa = a[9];
      qb = b[9];
    end else begin
      sa = a[31];
      sb = b[31];
      ma = a[30:0];
      mb = b[30:0];
      na = (a[30:23] == 8'hFF) && (a[22:0] != 0);
      nb = (b[30:23] == 8'hFF) && (b[22:0] != 0);
      qa = a[22];
      qb = b[22];
    end
    inv = 1'b0;
    if (op == fp_slice_pkg::MINMAX) begin
      inv = (na && !qa) || (nb && !qb);
      if (na && nb) return half ? 32'h0000_7E00 : 32'h7FC0_0000;
      if (na) return half ? {16'h0, b[15:0]} : b;
      if (nb) return half ? {16'h0, a[15:0]} : a;
      if (!max_sel) return value_less(sb, mb, sa, ma) ? (half ? {16'h0, b[15:0]} : b)
                                                      : (half ? {16'h0, a[15:0]} : a);
      return value_less(sa, ma, sb, mb) ? (half ? {16'h0, b[15:0]} : b)
                                        : (half ? {16'h0, a[15:0]} : a);
    end
    case (op)
      fp_slice_pkg::SGNJ:  s = sb;
      fp_slice_pkg::SGNJN: s = ~sb;
      default:             s = sa ^ sb;
    endcase
    return half ? {16'h0, s, ma[14:0]} : {s, ma};
  endfunction

  function automatic logic [31:0] expect_word(input logic [31:0] a, input logic [31:0] b,
      input fp_slice_pkg::operation_e op, input logic max_sel, input logic is16,
      input logic vec, input logic [1:0] mask, output logic inv);
    logic [31:0] lo, hi, a16, b16;
    logic        inv_lo, inv_hi;
    if (!is16) begin
      lo = lane_model(a, b, op, max_sel, 1'b0, inv_lo);
      inv = inv_lo & mask[0];
      return lo;
    end
    if (vec) begin
      lo = lane_model({16'h0, a[15:0]}, {16'h0, b[15:0]}, op, max_sel, 1'b1, inv_lo);
      hi = lane_model({16'h0, a[31:16]}, {16'h0, b[31:16]}, op, max_sel, 1'b1, inv_hi);
      inv = (inv_lo & mask[0]) | (inv_hi & mask[1]);
      return {hi[15:0], lo[15:0]};
    end
    // Scalar FP16 operands without all ones above bit 15 count as canonical NaN
    a16 = (a[31:16] == 16'hFFFF) ? {16'h0, a[15:0]} : 32'h0000_7E00;
    b16 = (b[31:16] == 16'hFFFF) ? {16'h0, b[15:0]} : 32'h0000_7E00;
    lo = lane_model(a16, b16, op, max_sel, 1'b1, inv_lo);
    inv = inv_lo & mask[0];
    return {16'hFFFF, lo[15:0]};
  endfunction

  // ----------------------------------------
  // Driving and monitoring
  // ----------------------------------------
  // Caller sits on a rising edge, returns on the accepting edge
  task automatic send(input logic [31:0] a, input logic [31:0] b,
      input fp_slice_pkg::operation_e op, input logic max_sel, input logic is16,
      input logic vec, input logic [3:0] tag, input logic [1:0] mask);
    logic acc;
    logic inv;
    logic [31:0] res;
    operand_a_i    <= a;
    operand_b_i    <= b;
    op_i           <= op;
    op_mod_i       <= max_sel;
    fmt_i          <= is16 ? fp_slice_pkg::FP16 : fp_slice_pkg::FP32;
    vectorial_op_i <= vec;
    tag_i          <= tag;
    simd_mask_i    <= mask;
    in_valid_i     <= 1'b1;
    res = expect_word(a, b, op, max_sel, is16, vec, mask, inv);
    exp_res.push_back(res);
    exp_inv.push_back(inv);
    exp_tag.push_back(tag);
    forever begin
      @(negedge clk_i);
      acc = in_ready_o;
      @(posedge clk_i);
      if (acc) break;
    end
  endtask

  task automatic go_idle();
    in_valid_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_res.size() != 0 || busy_o) && n < 40) begin
      @(negedge clk_i);
      n++;
    end
    assert (exp_res.size() == 0 && !busy_o) else begin
      $display("Pipeline did not drain, %0d results still missing", exp_res.size());
      other_errors++;
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_n_i && out_valid_o && out_ready_i) begin
      assert (exp_res.size() != 0) else begin
        $display("Result came out with no operation outstanding");
        other_errors++;
      end
      if (exp_res.size() != 0) begin
        assert (result_o === exp_res[0] && invalid_o === exp_inv[0] && tag_o === exp_tag[0])
        else begin
          $display("[FAIL] %0t result %h inv %b tag %h, expected %h inv %b tag %h", $time,
                   result_o, invalid_o, tag_o, exp_res[0], exp_inv[0], exp_tag[0]);
          value_errors++;
        end
        void'(exp_res.pop_front());
        void'(exp_inv.pop_front());
        void'(exp_tag.pop_front());
        rx_cyc.push_back(cyc);
      end
    end
  end

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_fp32_sgnj();
    @(posedge clk_i);
    for (int i = 0; i < 20; i++) begin
      case (i % 3)
        0: send($random(seed), $random(seed), fp_slice_pkg::SGNJ, 1'b0, 1'b0, 1'b0, 4'(i),
                2'b11);
        1: send($random(seed), $random(seed), fp_slice_pkg::SGNJN, 1'b0, 1'b0, 1'b0, 4'(i),
                2'b11);
        default: send($random(seed), $random(seed), fp_slice_pkg::SGNJX, 1'b0, 1'b0, 1'b0,
                      4'(i), 2'b11);
      endcase
    end
    go_idle();
    wait_drain();
  endtask

  task automatic test_fp16_boxing();
    @(posedge clk_i);
    send(32'hFFFF_3C00, 32'hFFFF_C000, fp_slice_pkg::SGNJ, 1'b0, 1'b1, 1'b0, 4'h1, 2'b01);
    send(32'hFFFF_BC00, 32'hFFFF_4000, fp_slice_pkg::MINMAX, 1'b0, 1'b1, 1'b0, 4'h2, 2'b01);
    send(32'hFFFF_BC00, 32'hFFFF_4000, fp_slice_pkg::MINMAX, 1'b1, 1'b1, 1'b0, 4'h3, 2'b01);
    // Badly boxed a, MINMAX returns b
    send(32'h1234_3C00, 32'hFFFF_4500, fp_slice_pkg::MINMAX, 1'b0, 1'b1, 1'b0, 4'h4, 2'b01);
    // Badly boxed b, min still returns a
    send(32'hFFFF_4500, 32'h0000_3C00, fp_slice_pkg::MINMAX, 1'b0, 1'b1, 1'b0, 4'h5, 2'b01);
    go_idle();
    wait_drain();
  endtask

  task automatic test_vec_minmax();
    @(posedge clk_i);
    send(32'h4000_7C01, 32'h3C00_3C00, fp_slice_pkg::MINMAX, 1'b0, 1'b1, 1'b1, 4'h1, 2'b01);
    send(32'h4000_7C01, 32'h3C00_3C00, fp_slice_pkg::MINMAX, 1'b0, 1'b1, 1'b1, 4'h2, 2'b10);
    send(32'h7C01_4000, 32'h3C00_3C00, fp_slice_pkg::MINMAX, 1'b1, 1'b1, 1'b1, 4'h3, 2'b10);
    send(32'h7C01_4000, 32'h3C00_3C00, fp_slice_pkg::MINMAX, 1'b1, 1'b1, 1'b1, 4'h4, 2'b01);
    for (int i = 0; i < 8; i++) begin
      send($random(seed), $random(seed), fp_slice_pkg::MINMAX, i[0], 1'b1, 1'b1, 4'(i),
           2'b11);
    end
    go_idle();
    wait_drain();
  endtask

  task automatic test_latency();
    out_ready_i <= 1'b1;
    @(posedge clk_i);
    send(32'h3F80_0000, 32'hC000_0000, fp_slice_pkg::SGNJ, 1'b0, 1'b0, 1'b0, 4'hA, 2'b01);
    go_idle();
    @(negedge clk_i);
    assert (!out_valid_o) else begin
      $display("[FAIL] %0t out_valid_o high one cycle after acceptance", $time);
      value_errors++;
    end
    @(negedge clk_i);
    assert (out_valid_o) else begin
      $display("[FAIL] %0t out_valid_o low two cycles after acceptance", $time);
      value_errors++;
    end
    wait_drain();
    rx_cyc.delete();
    @(posedge clk_i);
    for (int i = 0; i < 4; i++) begin
      send($random(seed), $random(seed), fp_slice_pkg::SGNJX, 1'b0, 1'b0, 1'b0, 4'(8 + i),
           2'b01);
    end
    go_idle();
    wait_drain();
    assert (rx_cyc.size() == 4 && rx_cyc[3] - rx_cyc[0] == 3) else begin
      $display("[FAIL] %0t back-to-back results not one per cycle", $time);
      value_errors++;
    end
  endtask

  task automatic test_backpressure();
    @(posedge clk_i);
    out_ready_i <= 1'b0;
    send(32'h4040_0000, 32'h8000_0000, fp_slice_pkg::SGNJN, 1'b0, 1'b0, 1'b0, 4'h6, 2'b01);
    send(32'hFFFF_4000, 32'hFFFF_3C00, fp_slice_pkg::MINMAX, 1'b1, 1'b1, 1'b0, 4'h7, 2'b01);
    go_idle();
    repeat (3) begin
      @(negedge clk_i);
      assert (!in_ready_o && out_valid_o) else begin
        $display("[FAIL] %0t in_ready_o %b out_valid_o %b under back-pressure", $time,
                 in_ready_o, out_valid_o);
        value_errors++;
      end
    end
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    wait_drain();
  endtask

  task automatic test_flush();
    @(posedge clk_i);
    out_ready_i <= 1'b0;
    send(32'h1111_2222, 32'h3333_4444, fp_slice_pkg::SGNJ, 1'b0, 1'b0, 1'b0, 4'h1, 2'b01);
    send(32'h5555_6666, 32'h7777_8888, fp_slice_pkg::SGNJ, 1'b0, 1'b0, 1'b0, 4'h2, 2'b01);
    go_idle();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    assert (!out_valid_o && !busy_o) else begin
      $display("[FAIL] %0t out_valid_o %b busy_o %b after flush", $time, out_valid_o, busy_o);
      value_errors++;
    end
    exp_res.delete();
    exp_inv.delete();
    exp_tag.delete();
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    send(32'h4080_0000, 32'h4000_0000, fp_slice_pkg::MINMAX, 1'b1, 1'b0, 1'b0, 4'h3, 2'b01);
    go_idle();
    wait_drain();
  endtask

  initial begin
    rst_n_i        = 1'b0;
    flush_i        = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    op_i           = fp_slice_pkg::SGNJ;
    op_mod_i       = 1'b0;
    fmt_i          = fp_slice_pkg::FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    simd_mask_i    = '0;
    in_valid_i     = 1'b0;
    out_ready_i    = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    assert (!out_valid_o && !busy_o && in_ready_o) else begin
      $display("[FAIL] %0t outputs not idle after reset", $time);
      value_errors++;
    end
    test_fp32_sgnj();
    test_fp16_boxing();
    test_vec_minmax();
    test_latency();
    test_backpressure();
    test_flush();
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== tb/slice_checker.sv ====
// Protocol assertions for the non-computational slice, bound to its top level
// Only the output handshake and the two-cycle latency are checked here

`timescale 1ns/1ns
`include "slice_settings.svh"

module slice_checker (
  input logic                       clk_i,
  input logic                       rst_n_i,
  input logic                       flush_i,
  input logic                       in_valid_i,
  input logic                       in_ready_o,
  input logic                       out_valid_o,
  input logic                       out_ready_i,
  input logic [`SLICE_WIDTH-1:0]    result_o,
  input logic [`SLICE_TAG_BITS-1:0] tag_o,
  input logic                       busy_o
);

  // Pipelines start empty
  reset_idle: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !busy_o && !out_valid_o)
    else $error("busy_o or out_valid_o high right after reset");

  // Output holds under back-pressure
  output_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i && !flush_i) |=>
      ($stable(out_valid_o) && $stable(result_o) && $stable(tag_o)))
    else $error("Output changed while out_ready_i was low");

  // A new result follows an accepted operation after two cycles
  latency_two: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(out_valid_o) |-> $past(in_valid_i && in_ready_o, 2))
    else $error("out_valid_o rose without an operation accepted two cycles earlier");

endmodule

bind noncomp_multifmt_slice slice_checker u_checker (
  .clk_i, .rst_n_i, .flush_i, .in_valid_i, .in_ready_o, .out_valid_o,
  .out_ready_i, .result_o, .tag_o, .busy_o
);

// ==== rtl/noncomp_multifmt_slice.sv ====
// Non-computational SIMD slice, FP32 scalar or up to two FP16 lanes
// Inputs must stay stable while in_valid_i is high and in_ready_o is low
// Lane 1 only follows vectorial FP16 operations, lane 0 leads the handshake

`timescale 1ns/1ns
`include "slice_settings.svh"

module noncomp_multifmt_slice (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,
  input  logic [`SLICE_WIDTH-1:0]      operand_a_i,
  input  logic [`SLICE_WIDTH-1:0]      operand_b_i,
  input  fp_slice_pkg::operation_e     op_i,
  input  logic                         op_mod_i,
  input  fp_slice_pkg::fp_format_e     fmt_i,
  input  logic                         vectorial_op_i,
  input  logic [`SLICE_TAG_BITS-1:0]   tag_i,
  input  logic [`SLICE_NUM_LANES-1:0]  simd_mask_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  output logic [`SLICE_WIDTH-1:0]      result_o,
  output logic                         invalid_o,
  output logic [`SLICE_TAG_BITS-1:0]   tag_o,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output logic                         busy_o
);

  localparam int unsigned Lane1Width = `SLICE_WIDTH / `SLICE_NUM_LANES;

  logic                        vectorial, scalar_fp16;
  logic                        box_a_ok, box_b_ok;
  fp_slice_pkg::lane_aux_t     aux_data, lane0_aux;
  logic                        lane1_in_valid, lane1_out_valid, lane1_out_ready;
  logic [`SLICE_WIDTH-1:0]     lane0_result;
  logic [Lane1Width-1:0]       lane1_result;
  logic [`SLICE_NUM_LANES-1:0] lane_invalid, lane_mask, lane_busy;

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  assign vectorial   = vectorial_op_i & (fmt_i == fp_slice_pkg::FP16);
  assign scalar_fp16 = ~vectorial_op_i & (fmt_i == fp_slice_pkg::FP16);

  // Scalar FP16 operands need all ones in the upper half
  assign box_a_ok = ~scalar_fp16 | (&operand_a_i[31:16]);
  assign box_b_ok = ~scalar_fp16 | (&operand_b_i[31:16]);

  assign aux_data       = '{vectorial: vectorial, dst_fmt: fmt_i};
  assign lane1_in_valid = in_valid_i & vectorial;  // Upper lane for vectors only

  // ----------------------------------------
  // Lanes
  // ----------------------------------------
  fp_noncomp_lane #(
    .LaneWidth ( `SLICE_WIDTH )
  ) u_lane0 (
    .clk_i, .rst_n_i, .flush_i,
    .operand_a_i ( operand_a_i           ),
    .operand_b_i ( operand_b_i           ),
    .op_i, .op_mod_i, .fmt_i,
    .box_ok_i    ( {box_b_ok, box_a_ok}  ),
    .tag_i,
    .mask_i      ( simd_mask_i[0]        ),
    .aux_i       ( aux_data              ),
    .in_valid_i  ( in_valid_i            ),
    .in_ready_o  ( in_ready_o            ),
    .result_o    ( lane0_result          ),
    .invalid_o   ( lane_invalid[0]       ),
    .mask_o      ( lane_mask[0]          ),
    .tag_o       ( tag_o                 ),
    .aux_o       ( lane0_aux             ),
    .out_valid_o ( out_valid_o           ),
    .out_ready_i ( out_ready_i           ),
    .busy_o      ( lane_busy[0]          )
  );

  // Lane 1 pops only when lane 0 shows a vectorial result
  assign lane1_out_ready = out_ready_i & lane0_aux.vectorial;

  fp_noncomp_lane #(
    .LaneWidth ( Lane1Width )
  ) u_lane1 (
    .clk_i, .rst_n_i, .flush_i,
    .operand_a_i ( operand_a_i[31:16]    ),
    .operand_b_i ( operand_b_i[31:16]    ),
    .op_i, .op_mod_i, .fmt_i,
    .box_ok_i    ( 2'b11                 ),  // Vector halves are never boxed
    .tag_i,
    .mask_i      ( simd_mask_i[1]        ),
    .aux_i       ( aux_data              ),
    .in_valid_i  ( lane1_in_valid        ),
    .in_ready_o  (                       ),
    .result_o    ( lane1_result          ),
    .invalid_o   ( lane_invalid[1]       ),
    .mask_o      ( lane_mask[1]          ),
    .tag_o       (                       ),
    .aux_o       (                       ),
    .out_valid_o ( lane1_out_valid       ),
    .out_ready_i ( lane1_out_ready       ),
    .busy_o      ( lane_busy[1]          )
  );

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  slice_result_packer u_packer (
    .lane0_result_i ( lane0_result    ),
    .lane1_result_i ( lane1_result    ),
    .lane1_valid_i  ( lane1_out_valid ),
    .lane_invalid_i ( lane_invalid    ),
    .lane_mask_i    ( lane_mask       ),
    .aux_i          ( lane0_aux       ),
    .result_o       ( result_o        ),
    .invalid_o      ( invalid_o       )
  );

  assign busy_o = |lane_busy;

endmodule

// ==== rtl/slice_result_packer.sv ====
// Output packing of the two lane results into one slice word
// FP16 words take lane 1 in the upper half only when it delivered a result
// The invalid flag counts only lanes that are enabled in the SIMD mask

`timescale 1ns/1ns
`include "slice_settings.svh"

module slice_result_packer (
  input  logic [31:0]                  lane0_result_i,
  input  logic [15:0]                  lane1_result_i,
  input  logic                         lane1_valid_i,
  input  logic [`SLICE_NUM_LANES-1:0]  lane_invalid_i,
  input  logic [`SLICE_NUM_LANES-1:0]  lane_mask_i,
  input  fp_slice_pkg::lane_aux_t      aux_i,
  output logic [`SLICE_WIDTH-1:0]      result_o,
  output logic                         invalid_o
);

  logic                        lane1_used;
  logic [`SLICE_NUM_LANES-1:0] lane_delivered;

  // Lane 1 only counts for vectorial results
  assign lane1_used     = lane1_valid_i & aux_i.vectorial;
  assign lane_delivered = {lane1_used, 1'b1};  // Lane 0 always delivers with out_valid

  // ----------------------------------------
  // Result packing
  // ----------------------------------------
  always_comb begin : pack_result
    if (aux_i.dst_fmt == fp_slice_pkg::FP32) begin
      result_o = lane0_result_i;
    end else begin
      // Upper half NaN-boxed when lane 1 is idle
      result_o = {(lane1_used ? lane1_result_i : 16'hFFFF), lane0_result_i[15:0]};
    end
  end

  // ----------------------------------------
  // Status collapse
  // ----------------------------------------
  always_comb begin : collapse_status
    invalid_o = 1'b0;
    for (int i = 0; i < `SLICE_NUM_LANES; i++) begin
      invalid_o = invalid_o | (lane_invalid_i[i] & lane_mask_i[i] & lane_delivered[i]);
    end
  end

endmodule

// ==== rtl/fp_noncomp_lane.sv ====
// One SIMD lane for sign injection and MINMAX
// A lane narrower than the slice width handles FP16 only
// Results of FP16 operations carry all ones above bit 15
// The output holds while out_ready_i is low, flush_i drops all items in flight

`timescale 1ns/1ns
`include "slice_settings.svh"

module fp_noncomp_lane #(
  parameter int unsigned LaneWidth = 32
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          flush_i,
  input  logic [LaneWidth-1:0]          operand_a_i,
  input  logic [LaneWidth-1:0]          operand_b_i,
  input  fp_slice_pkg::operation_e      op_i,
  input  logic                          op_mod_i,
  input  fp_slice_pkg::fp_format_e      fmt_i,
  input  logic [1:0]                    box_ok_i,
  input  logic [`SLICE_TAG_BITS-1:0]    tag_i,
  input  logic                          mask_i,
  input  fp_slice_pkg::lane_aux_t       aux_i,
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  output logic [LaneWidth-1:0]          result_o,
  output logic                          invalid_o,
  output logic                          mask_o,
  output logic [`SLICE_TAG_BITS-1:0]    tag_o,
  output fp_slice_pkg::lane_aux_t       aux_o,
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output logic                          busy_o
);

  localparam int unsigned NumRegs = `SLICE_PIPE_REGS;
  localparam int unsigned W       = `SLICE_WIDTH;

  logic         is_fp32;
  logic [W-1:0] sign_bit, mag_mask, inf_bits, quiet_bit, canon_nan, upper_fill;
  logic [W-1:0] opa, opb, mag_a, mag_b;
  logic         sign_a, sign_b;
  logic         nan_a, nan_b, snan_a, snan_b;
  logic         a_lt_b;
  logic [W-1:0] res_full;
  logic         op_invalid;

  // ----------------------------------------
  // Operation
  // ----------------------------------------
  assign is_fp32 = (LaneWidth >= W) && (fmt_i == fp_slice_pkg::FP32);

  always_comb begin : fmt_constants
    if (is_fp32) begin
      sign_bit   = 32'h8000_0000;
      mag_mask   = 32'h7FFF_FFFF;
      inf_bits   = 32'h7F80_0000;
      quiet_bit  = 32'h0040_0000;
      canon_nan  = fp_slice_pkg::CANON_NAN32;
      upper_fill = '0;
    end else begin
      sign_bit   = 32'h0000_8000;
      mag_mask   = 32'h0000_7FFF;
      inf_bits   = 32'h0000_7C00;
      quiet_bit  = 32'h0000_0200;
      canon_nan  = {16'hFFFF, fp_slice_pkg::CANON_NAN16};
      upper_fill = 32'hFFFF_0000;  // NaN-box FP16 results
    end
  end

  // Badly boxed operands turn into the canonical NaN
  assign opa = box_ok_i[0] ? W'(operand_a_i) : canon_nan;
  assign opb = box_ok_i[1] ? W'(operand_b_i) : canon_nan;

  assign sign_a = |(opa & sign_bit);
  assign sign_b = |(opb & sign_bit);
  assign mag_a  = opa & mag_mask;
  assign mag_b  = opb & mag_mask;
  assign nan_a  = mag_a > inf_bits;  // Exponent all ones, mantissa nonzero
  assign nan_b  = mag_b > inf_bits;
  assign snan_a = nan_a & ~|(opa & quiet_bit);
  assign snan_b = nan_b & ~|(opb & quiet_bit);

  // Sign-magnitude ordering, -0 sorts below +0
  always_comb begin : order
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  always_comb begin : compute
    res_full   = mag_a;
    op_invalid = 1'b0;
    unique case (op_i)
      fp_slice_pkg::SGNJ:  res_full = mag_a | (sign_b ? sign_bit : '0);
      fp_slice_pkg::SGNJN: res_full = mag_a | (sign_b ? '0 : sign_bit);
      fp_slice_pkg::SGNJX: res_full = mag_a | ((sign_a ^ sign_b) ? sign_bit : '0);
      fp_slice_pkg::MINMAX: begin
        op_invalid = snan_a | snan_b;
        if (nan_a && nan_b) begin
          res_full = canon_nan;
        end else if (nan_a) begin
          res_full = opb;
        end else if (nan_b) begin
          res_full = opa;
        end else if (a_lt_b ^ op_mod_i) begin  // Min keeps a when smaller, max otherwise
          res_full = opa;
        end else begin
          res_full = opb;
        end
      end
      default: res_full = mag_a;
    endcase
    res_full = (res_full & (sign_bit | mag_mask)) | upper_fill;
  end

  // ----------------------------------------
  // Pipeline
  // ----------------------------------------
  // Index i is the state after i register stages
  logic [0:NumRegs][LaneWidth-1:0]       pipe_result_q;
  logic [0:NumRegs]                      pipe_invalid_q, pipe_mask_q;
  logic [0:NumRegs][`SLICE_TAG_BITS-1:0] pipe_tag_q;
  fp_slice_pkg::lane_aux_t [0:NumRegs]   pipe_aux_q;
  logic [0:NumRegs]                      pipe_valid_q;
  logic [0:NumRegs]                      pipe_ready;

  assign pipe_result_q[0]  = res_full[LaneWidth-1:0];
  assign pipe_invalid_q[0] = op_invalid;
  assign pipe_mask_q[0]    = mask_i;
  assign pipe_tag_q[0]     = tag_i;
  assign pipe_aux_q[0]     = aux_i;
  assign pipe_valid_q[0]   = in_valid_i;

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stages
    logic reg_ena;

    // Advance when the next stage moves on or only holds a bubble
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid_q[i+1];
    assign reg_ena       = pipe_ready[i] & pipe_valid_q[i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        pipe_valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        pipe_valid_q[i+1] <= 1'b0;
      end else if (pipe_ready[i]) begin
        pipe_valid_q[i+1] <= pipe_valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_ena) begin
        pipe_result_q[i+1]  <= pipe_result_q[i];
        pipe_invalid_q[i+1] <= pipe_invalid_q[i];
        pipe_mask_q[i+1]    <= pipe_mask_q[i];
        pipe_tag_q[i+1]     <= pipe_tag_q[i];
        pipe_aux_q[i+1]     <= pipe_aux_q[i];
      end
    end
  end

  assign pipe_ready[NumRegs] = out_ready_i;  // Downstream ready

  assign in_ready_o  = pipe_ready[0];
  assign result_o    = pipe_result_q[NumRegs];
  assign invalid_o   = pipe_invalid_q[NumRegs];
  assign mask_o      = pipe_mask_q[NumRegs];
  assign tag_o       = pipe_tag_q[NumRegs];
  assign aux_o       = pipe_aux_q[NumRegs];
  assign out_valid_o = pipe_valid_q[NumRegs];
  assign busy_o      = |pipe_valid_q[1:NumRegs];

endmodule

// ==== rtl/fp_slice_pkg.sv ====
// Shared types for the non-computational SIMD slice
// Formats are limited to FP32 and FP16, opcodes to sign injection and MINMAX
// The canonical NaNs are the quiet NaNs with a cleared sign and payload

package fp_slice_pkg;

  // Floating-point formats handled by the slice
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  // Non-computational opcodes
  typedef enum logic [1:0] {
    SGNJ   = 2'd0,
    SGNJN  = 2'd1,
    SGNJX  = 2'd2,
    MINMAX = 2'd3  // op_mod selects min (0) or max (1)
  } operation_e;

  // Format data carried along with lane 0
  typedef struct packed {
    logic       vectorial;
    fp_format_e dst_fmt;
  } lane_aux_t;

  // Canonical quiet NaNs
  localparam logic [31:0] CANON_NAN32 = 32'h7FC0_0000;
  localparam logic [15:0] CANON_NAN16 = 16'h7E00;

endpackage

// ==== rtl/slice_settings.svh ====
// Build-time dimensions of the non-computational SIMD slice
// Only a 32-bit slice with FP32 and two FP16 lanes is supported
// The lane count must stay equal to the width divided by 16

`ifndef SLICE_SETTINGS_SVH
`define SLICE_SETTINGS_SVH

// Datapath width in bits
`define SLICE_WIDTH 32

// Maximum number of SIMD lanes (FP16 packed into the datapath)
`define SLICE_NUM_LANES 2

// Register stages inside every lane
`define SLICE_PIPE_REGS 2

// Width of the tag that travels with an operation
`define SLICE_TAG_BITS 4

`endif
